// ==== hw/eth_tx_pkg.sv ====
package eth_tx_pkg;

    // memory side
    localparam int ADDR_WIDTH = 10;
    localparam int LEN_WIDTH  = 12;
    localparam int TAG_WIDTH  = 8;
    localparam int WORD_BYTES = 8;

    // output side with four beats per memory word
    localparam int BEAT_BYTES = 2;
    localparam int LANES      = WORD_BYTES / BEAT_BYTES;
    localparam int LANE_WIDTH = $clog2(LANES);

    // word buffer depth doubles as the fetch credit start value
    localparam int FIFO_DEPTH     = 4;
    localparam int FIFO_PTR_WIDTH = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_WIDTH = $clog2(FIFO_DEPTH + 1);

    localparam int OUT_CREDITS   = 4;
    localparam int OUT_CNT_WIDTH = $clog2(OUT_CREDITS + 1);

    typedef enum logic {
        FETCH_IDLE,
        FETCH_READ
    } fetch_state_t;

    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
        logic [LEN_WIDTH-1:0]  len;
        logic [TAG_WIDTH-1:0]  tag;
    } tx_desc_t;

    typedef struct packed {
        logic [WORD_BYTES*8-1:0] data;
        logic [WORD_BYTES-1:0]   keep;
        logic                    last;
        logic [TAG_WIDTH-1:0]    tag;
    } tx_word_t;

    typedef struct packed {
        logic [BEAT_BYTES*8-1:0] data;
        logic [BEAT_BYTES-1:0]   keep;
        logic                    last;
        logic [TAG_WIDTH-1:0]    tag;
    } tx_beat_t;

endpackage

// ==== hw/tx_desc_fetch.sv ====
module tx_desc_fetch (
    input  logic                                logic_clk,
    input  logic                                logic_rst,
    input  logic                                tx_enable,
    input  eth_tx_pkg::tx_desc_t                desc,
    input  logic                                desc_valid,
    output logic                                desc_ready,
    output logic                                rd_en,
    output logic [eth_tx_pkg::ADDR_WIDTH-1:0]   rd_addr,
    input  logic [eth_tx_pkg::WORD_BYTES*8-1:0] rd_data,
    input  logic                                credit_ret,
    output eth_tx_pkg::tx_word_t                word,
    output logic                                word_push
);

    import eth_tx_pkg::*;

    fetch_state_t              state;
    logic [ADDR_WIDTH-1:0]     addr_q;
    logic [LEN_WIDTH-1:0]      remain_q;
    logic [TAG_WIDTH-1:0]      tag_q;
    logic [FIFO_CNT_WIDTH-1:0] credit_cnt;

    logic                      last_rd;
    logic [WORD_BYTES-1:0]     keep_rd;

    // sideband delayed by one cycle to line up with rd_data
    logic                      push_d;
    logic                      last_d;
    logic [WORD_BYTES-1:0]     keep_d;
    logic [TAG_WIDTH-1:0]      tag_d;

    assign desc_ready = (state == FETCH_IDLE) && tx_enable;
    assign rd_en      = (state == FETCH_READ) && (credit_cnt != '0);
    assign rd_addr    = addr_q;

    // final word when no more than one word of bytes is left
    assign last_rd = (remain_q <= LEN_WIDTH'(WORD_BYTES));

    always_comb begin
        for (int i = 0; i < WORD_BYTES; i++) begin
            keep_rd[i] = !last_rd || (remain_q > LEN_WIDTH'(i));
        end
    end

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            state      <= FETCH_IDLE;
            addr_q     <= '0;
            remain_q   <= '0;
            tag_q      <= '0;
            credit_cnt <= FIFO_CNT_WIDTH'(FIFO_DEPTH);
            push_d     <= 1'b0;
        end else begin
            credit_cnt <= credit_cnt - FIFO_CNT_WIDTH'(rd_en) + FIFO_CNT_WIDTH'(credit_ret);
            push_d     <= rd_en;
            case (state)
                FETCH_IDLE: begin
                    if (desc_valid && desc_ready) begin
                        addr_q   <= desc.addr;
                        remain_q <= desc.len;
                        tag_q    <= desc.tag;
                        state    <= FETCH_READ;
                    end
                end
                FETCH_READ: begin
                    if (rd_en) begin
                        addr_q   <= addr_q + 1'b1;
                        remain_q <= remain_q - LEN_WIDTH'(WORD_BYTES);
                        if (last_rd) begin
                            state <= FETCH_IDLE;
                        end
                    end
                end
                default: state <= FETCH_IDLE;
            endcase
        end
    end

    always_ff @(posedge logic_clk) begin
        last_d <= last_rd;
        keep_d <= keep_rd;
        tag_d  <= tag_q;
    end

    assign word_push = push_d;
    assign word      = '{data: rd_data, keep: keep_d, last: last_d, tag: tag_d};

    // returned credits can never outnumber the buffer entries
    assert property (@(posedge logic_clk) disable iff (logic_rst)
        credit_cnt <= FIFO_CNT_WIDTH'(FIFO_DEPTH));

endmodule

// ==== hw/tx_word_fifo.sv ====
module tx_word_fifo (
    input  logic                 logic_clk,
    input  logic                 logic_rst,
    input  eth_tx_pkg::tx_word_t in_word,
    input  logic                 push,
    output eth_tx_pkg::tx_word_t out_word,
    output logic                 out_valid,
    input  logic                 out_ready,
    output logic                 credit_ret
);

    import eth_tx_pkg::*;

    tx_word_t                  mem [FIFO_DEPTH];
    logic [FIFO_PTR_WIDTH-1:0] wr_ptr;
    logic [FIFO_PTR_WIDTH-1:0] rd_ptr;
    logic [FIFO_CNT_WIDTH-1:0] count;
    logic                      pop;

    assign out_valid  = (count != '0);
    assign out_word   = mem[rd_ptr];
    assign pop        = out_valid && out_ready;
    // each freed entry goes straight back to fetch
    assign credit_ret = pop;

    always_ff @(posedge logic_clk) begin
        if (push) begin
            mem[wr_ptr] <= in_word;
        end
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + FIFO_CNT_WIDTH'(push) - FIFO_CNT_WIDTH'(pop);
        end
    end

    // fetch credits must keep pushes away from a full buffer
    assert property (@(posedge logic_clk) disable iff (logic_rst)
        push |-> count != FIFO_CNT_WIDTH'(FIFO_DEPTH));

endmodule

// ==== hw/tx_width_adapter.sv ====
module tx_width_adapter (
    input  logic                 logic_clk,
    input  logic                 logic_rst,
    input  eth_tx_pkg::tx_word_t in_word,
    input  logic                 in_valid,
    output logic                 in_ready,
    output eth_tx_pkg::tx_beat_t beat,
    output logic                 beat_valid,
    input  logic                 beat_ready
);

    import eth_tx_pkg::*;

    logic [LANE_WIDTH-1:0] lane_q;
    logic [LANES-1:0]      lane_used;
    logic [LANES-1:0]      lane_final;
    logic                  beat_done;

    // keep is filled from byte 0 up, so empty lanes only trail the word
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            lane_used[i] = |in_word.keep[i*BEAT_BYTES +: BEAT_BYTES];
        end
        for (int i = 0; i < LANES - 1; i++) begin
            lane_final[i] = lane_used[i] && !lane_used[i+1];
        end
        lane_final[LANES-1] = lane_used[LANES-1];
    end

    assign beat_valid = in_valid;
    assign beat.data  = in_word.data[lane_q*(BEAT_BYTES*8) +: BEAT_BYTES*8];
    assign beat.keep  = in_word.keep[lane_q*BEAT_BYTES +: BEAT_BYTES];
    assign beat.last  = in_word.last && lane_final[lane_q];
    assign beat.tag   = in_word.tag;

    assign beat_done = beat_valid && beat_ready;
    // word leaves with its last non-empty lane
    assign in_ready  = beat_ready && lane_final[lane_q];

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            lane_q <= '0;
        end else if (beat_done) begin
            if (lane_final[lane_q]) begin
                lane_q <= '0;
            end else begin
                lane_q <= lane_q + 1'b1;
            end
        end
    end

    // relies on fetch building contiguous keep, so no empty beat goes out
    assert property (@(posedge logic_clk) disable iff (logic_rst)
        beat_valid |-> beat.keep != '0);

endmodule

// ==== hw/tx_credit_out.sv ====
module tx_credit_out (
    input  logic                               logic_clk,
    input  logic                               logic_rst,
    input  eth_tx_pkg::tx_beat_t               in_beat,
    input  logic                               in_valid,
    output logic                               in_ready,
    output eth_tx_pkg::tx_beat_t               beat,
    output logic                               beat_valid,
    input  logic                               beat_credit,
    output logic [eth_tx_pkg::TAG_WIDTH-1:0]   status_tag,
    output logic                               status_valid
);

    import eth_tx_pkg::*;

    logic [OUT_CNT_WIDTH-1:0] credit_cnt;
    logic                     accept;

    // the beat in the output register still owns one credit
    assign in_ready = (credit_cnt > OUT_CNT_WIDTH'(beat_valid));
    assign accept   = in_valid && in_ready;

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            credit_cnt   <= OUT_CNT_WIDTH'(OUT_CREDITS);
            beat_valid   <= 1'b0;
            status_valid <= 1'b0;
        end else begin
            credit_cnt   <= credit_cnt - OUT_CNT_WIDTH'(beat_valid)
                            + OUT_CNT_WIDTH'(beat_credit);
            beat_valid   <= accept;
            status_valid <= beat_valid && beat.last;
        end
    end

    always_ff @(posedge logic_clk) begin
        if (accept) begin
            beat <= in_beat;
        end
        status_tag <= beat.tag;
    end

    // downstream never returns more than it was given
    assert property (@(posedge logic_clk) disable iff (logic_rst)
        credit_cnt <= OUT_CNT_WIDTH'(OUT_CREDITS));

endmodule

// ==== hw/eth_tx_dma.sv ====
module eth_tx_dma (
    input  logic                                logic_clk,
    input  logic                                logic_rst,
    input  logic                                tx_enable,
    input  eth_tx_pkg::tx_desc_t                desc,
    input  logic                                desc_valid,
    output logic                                desc_ready,
    output logic                                rd_en,
    output logic [eth_tx_pkg::ADDR_WIDTH-1:0]   rd_addr,
    input  logic [eth_tx_pkg::WORD_BYTES*8-1:0] rd_data,
    output eth_tx_pkg::tx_beat_t                beat,
    output logic                                beat_valid,
    input  logic                                beat_credit,
    output logic [eth_tx_pkg::TAG_WIDTH-1:0]    status_tag,
    output logic                                status_valid
);

    import eth_tx_pkg::*;

    tx_word_t fetch_word;
    logic     fetch_push;
    logic     credit_ret;

    tx_word_t fifo_word;
    logic     fifo_valid;
    logic     fifo_ready;

    tx_beat_t adapt_beat;
    logic     adapt_valid;
    logic     adapt_ready;

    tx_desc_fetch u_fetch (
        .logic_clk  (logic_clk),
        .logic_rst  (logic_rst),
        .tx_enable  (tx_enable),
        .desc       (desc),
        .desc_valid (desc_valid),
        .desc_ready (desc_ready),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .credit_ret (credit_ret),
        .word       (fetch_word),
        .word_push  (fetch_push)
    );

    tx_word_fifo u_fifo (
        .logic_clk  (logic_clk),
        .logic_rst  (logic_rst),
        .in_word    (fetch_word),
        .push       (fetch_push),
        .out_word   (fifo_word),
        .out_valid  (fifo_valid),
        .out_ready  (fifo_ready),
        .credit_ret (credit_ret)
    );

    tx_width_adapter u_adapter (
        .logic_clk  (logic_clk),
        .logic_rst  (logic_rst),
        .in_word    (fifo_word),
        .in_valid   (fifo_valid),
        .in_ready   (fifo_ready),
        .beat       (adapt_beat),
        .beat_valid (adapt_valid),
        .beat_ready (adapt_ready)
    );

    tx_credit_out u_out (
        .logic_clk    (logic_clk),
        .logic_rst    (logic_rst),
        .in_beat      (adapt_beat),
        .in_valid     (adapt_valid),
        .in_ready     (adapt_ready),
        .beat         (beat),
        .beat_valid   (beat_valid),
        .beat_credit  (beat_credit),
        .status_tag   (status_tag),
        .status_valid (status_valid)
    );

endmodule

// ==== include/tb_eth_tx_tasks.svh ====
// expected frame byte i from the memory layout
function automatic logic [7:0] frame_byte(input int addr, input int i);
    logic [WORD_BYTES*8-1:0] w;
    w = mem[ADDR_WIDTH'(addr + i / WORD_BYTES)];
    return w[8*(i % WORD_BYTES) +: 8];
endfunction

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    assert (expected === actual) else begin
        $display("FAILED at time %0t: %s expected %0h, actual %0h",
                 $time, name, expected, actual);
        abort_run("an output did not match its expected value");
    end
endtask

task automatic wait_queues(input int beats, input int statuses);
    int cycles;
    cycles = 0;
    while (beat_q.size() < beats || status_q.size() < statuses) begin
        @(negedge logic_clk);
        cycles++;
        if (cycles > WAIT_LIMIT) begin
            abort_run("timed out waiting for output beats or a status pulse");
        end
    end
endtask

task automatic send_desc(input int addr, input int len, input int tag);
    int cycles;
    cycles = 0;
    desc = '{addr: ADDR_WIDTH'(addr), len: LEN_WIDTH'(len), tag: TAG_WIDTH'(tag)};
    desc_valid = 1'b1;
    while (!desc_ready) begin
        @(negedge logic_clk);
        cycles++;
        if (cycles > WAIT_LIMIT) begin
            abort_run("the descriptor was never accepted");
        end
    end
    // transfer happens on the coming rising edge
    @(negedge logic_clk);
    desc_valid = 1'b0;
endtask

// beat j carries frame bytes 2j and 2j+1
task automatic expect_frame(input int addr, input int len, input int tag);
    tx_beat_t b;
    int       n;
    n = (len + 1) / 2;
    for (int j = 0; j < n; j++) begin
        wait_queues(1, 0);
        b = beat_q.pop_front();
        check_value("beat.data[7:0]", 32'(frame_byte(addr, 2*j)), 32'(b.data[7:0]));
        if (2*j + 1 < len) begin
            check_value("beat.data[15:8]", 32'(frame_byte(addr, 2*j + 1)),
                        32'(b.data[15:8]));
        end
        check_value("beat.keep", (2*j + 1 < len) ? 32'd3 : 32'd1, 32'(b.keep));
        check_value("beat.last", 32'(j == n - 1), 32'(b.last));
        check_value("beat.tag", 32'(tag), 32'(b.tag));
    end
endtask

task automatic expect_status(input int tag);
    wait_queues(0, 1);
    check_value("status_tag", 32'(tag), 32'(status_q.pop_front()));
endtask

task automatic run_frame(input int addr, input int len, input int tag);
    send_desc(addr, len, tag);
    expect_frame(addr, len, tag);
    expect_status(tag);
endtask

task automatic check_idle_outputs();
    check_value("rd_en", 0, 32'(rd_en));
    check_value("beat_valid", 0, 32'(beat_valid));
    check_value("status_valid", 0, 32'(status_valid));
    check_value("credit_ret", 0, 32'(i_dut.credit_ret));
    check_value("desc_ready", 32'(tx_enable), 32'(desc_ready));
endtask

task automatic test_single_frame();
    run_frame(5, 16, 8'h11);
endtask

// short and odd lengths leave part of the final word empty
task automatic test_partial_words();
    run_frame(100, 1, 8'h21);
    run_frame(200, 13, 8'h22);
    run_frame(300, 9, 8'h23);
endtask

task automatic test_back_to_back();
    send_desc(400, 24, 8'h31);
    send_desc(410, 7, 8'h32);
    send_desc(420, 18, 8'h33);
    expect_frame(400, 24, 8'h31);
    expect_frame(410, 7, 8'h32);
    expect_frame(420, 18, 8'h33);
    expect_status(8'h31);
    expect_status(8'h32);
    expect_status(8'h33);
endtask

task automatic test_credit_pause();
    int cycles;
    cycles = 0;
    while (owed != 0) begin
        @(negedge logic_clk);
        cycles++;
        if (cycles > WAIT_LIMIT) begin
            abort_run("credits from the earlier frames were never returned");
        end
    end
    credit_auto = 1'b0;
    send_desc(500, 40, 8'h41);
    wait_queues(OUT_CREDITS, 0);
    // no credit left, so the output has to stay quiet
    for (int k = 0; k < 30; k++) begin
        @(negedge logic_clk);
        check_value("beats received", OUT_CREDITS, beat_q.size());
    end
    credit_auto = 1'b1;
    expect_frame(500, 40, 8'h41);
    expect_status(8'h41);
endtask

task automatic test_disabled();
    tx_enable = 1'b0;
    desc = '{addr: ADDR_WIDTH'(600), len: LEN_WIDTH'(11), tag: TAG_WIDTH'(8'h51)};
    desc_valid = 1'b1;
    for (int k = 0; k < 20; k++) begin
        @(negedge logic_clk);
        check_value("desc_ready", 0, 32'(desc_ready));
        check_value("rd_en", 0, 32'(rd_en));
        check_value("beat_valid", 0, 32'(beat_valid));
    end
    // the waiting descriptor transfers on the next rising edge
    tx_enable = 1'b1;
    @(negedge logic_clk);
    desc_valid = 1'b0;
    expect_frame(600, 11, 8'h51);
    expect_status(8'h51);
endtask

// ==== test/tb_eth_tx_dma.sv ====
module tb_eth_tx_dma;

    import eth_tx_pkg::*;

    localparam int WAIT_LIMIT = 400;
    localparam int RUN_LIMIT  = 20000;

    logic                    logic_clk = 1'b0;
    logic                    logic_rst;
    logic                    tx_enable;
    tx_desc_t                desc;
    logic                    desc_valid;
    logic                    desc_ready;
    logic                    rd_en;
    logic [ADDR_WIDTH-1:0]   rd_addr;
    logic [WORD_BYTES*8-1:0] rd_data = '0;
    tx_beat_t                beat;
    logic                    beat_valid;
    logic                    beat_credit = 1'b0;
    logic [TAG_WIDTH-1:0]    status_tag;
    logic                    status_valid;

    logic [WORD_BYTES*8-1:0] mem [1024];
    logic                    rd_pend = 1'b0;
    logic [ADDR_WIDTH-1:0]   rd_pend_addr = '0;
    logic                    credit_auto = 1'b1;
    int                      owed = 0;
    logic                    last_sent = 1'b0;
    tx_beat_t                beat_q[$];
    logic [TAG_WIDTH-1:0]    status_q[$];
    int                      seed = 15999;

    eth_tx_dma i_dut (.*);

    initial begin
        forever #2 logic_clk = ~logic_clk;
    end

    task automatic abort_run(input string reason);
        $display("ERROR at time %0t: %s", $time, reason);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    `include "tb_eth_tx_tasks.svh"

    // read data shows up one cycle after the read
    always @(negedge logic_clk) begin
        if (rd_pend) begin
            rd_data <= mem[rd_pend_addr];
        end
        rd_pend      <= rd_en;
        rd_pend_addr <= rd_addr;
    end

    // each beat's credit comes back a cycle later, held while paused
    always @(negedge logic_clk) begin
        if (beat_valid) begin
            assert (owed < OUT_CREDITS) else begin
                abort_run("a beat went out while downstream held every credit");
            end
        end
        if (credit_auto && owed > 0) begin
            beat_credit = 1'b1;
            owed = owed - 1;
        end else begin
            beat_credit = 1'b0;
        end
        if (beat_valid) begin
            owed = owed + 1;
        end
    end

    // status must follow the last beat by one cycle
    always @(negedge logic_clk) begin
        if (!logic_rst) begin
            if (status_valid) begin
                assert (last_sent) else begin
                    abort_run("status pulse without a last beat before it");
                end
                status_q.push_back(status_tag);
            end else begin
                assert (!last_sent) else begin
                    abort_run("no status pulse one cycle after a last beat");
                end
            end
            last_sent = beat_valid && beat.last;
            if (beat_valid) begin
                beat_q.push_back(beat);
            end
        end
    end

    initial begin
        for (int k = 0; k < RUN_LIMIT; k++) begin
            @(posedge logic_clk);
        end
        abort_run("the simulation ran past its cycle limit");
    end

    initial begin
        // low word bits mixed with the address
        for (int i = 0; i < 1024; i++) begin
            mem[i] = {$random(seed), $random(seed) ^ i};
        end
        logic_rst  = 1'b1;
        tx_enable  = 1'b1;
        desc       = '0;
        desc_valid = 1'b0;
        repeat (4) @(negedge logic_clk);
        logic_rst = 1'b0;
        check_idle_outputs();
        test_single_frame();
        test_partial_words();
        test_back_to_back();
        test_credit_pause();
        test_disabled();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// ==== eth_tx_dma.f ====
hw/eth_tx_pkg.sv
hw/tx_desc_fetch.sv
hw/tx_word_fifo.sv
hw/tx_width_adapter.sv
hw/tx_credit_out.sv
hw/eth_tx_dma.sv
+incdir+include
test/tb_eth_tx_dma.sv

// ==== Makefile ====
# Verilator build and run of the transmit DMA testbench

VERILATOR ?= verilator
TOP       ?= tb_eth_tx_dma
FILELIST  ?= eth_tx_dma.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
